//--- design/aes_consts.svh
/*
 * AES-128 pipeline constants
 * Widths, round count and the fixed input-to-output latency
 */
`ifndef AES_CONSTS_SVH
`define AES_CONSTS_SVH

// Data widths
`define AES_BLOCK_W 128
`define AES_WORD_W 32
`define AES_BYTE_W 8

// Ten rounds for a 128-bit key
`define AES_ROUNDS 10

// Two register levels per round, plus one for whitening
`define AES_STAGE_LAT 2
`define AES_LATENCY (1 + `AES_ROUNDS * `AES_STAGE_LAT)

`endif

//--- design/aesPkg.sv
/*
 * AES-128 shared types and GF(2^8) helper functions
 * S-box is computed as field inverse plus affine transform
 */
`include "aes_consts.svh"

package aesPkg;

    typedef logic [`AES_BLOCK_W-1:0] aesBlock;
    typedef logic [`AES_WORD_W-1:0] aesWord;
    typedef logic [`AES_BYTE_W-1:0] aesByte;

    //////////////////////////////////////////////////
    // Field arithmetic
    //////////////////////////////////////////////////

    // Multiply by x, reduce by 0x11b
    function automatic aesByte xtimeByte(input aesByte b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    // Shift-and-add multiply
    function automatic aesByte gfMul(input aesByte a, input aesByte b);
        aesByte acc;
        aesByte cur;
        acc = '0;
        cur = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ cur;
            end
            cur = xtimeByte(cur);
        end
        return acc;
    endfunction

    //////////////////////////////////////////////////
    // S-box and round constants
    //////////////////////////////////////////////////

    function automatic aesByte sboxByte(input aesByte b);
        aesByte inv;
        aesByte sq;
        // Inverse as b^254, i.e. the product b^2 * b^4 * ... * b^128
        // Zero maps to zero as required
        inv = 8'h01;
        sq = b;
        for (int i = 1; i < 8; i++) begin
            sq = gfMul(sq, sq);
            inv = gfMul(inv, sq);
        end
        // Affine transform
        return inv
            ^ {inv[6:0], inv[7]}
            ^ {inv[5:0], inv[7:6]}
            ^ {inv[4:0], inv[7:5]}
            ^ {inv[3:0], inv[7:4]}
            ^ 8'h63;
    endfunction

    // Round index 1..10 gives 01, 02, ... 80, 1b, 36
    function automatic aesByte roundConst(input int unsigned idx);
        aesByte rc;
        rc = 8'h01;
        for (int unsigned i = 1; i < idx; i++) begin
            rc = xtimeByte(rc);
        end
        return rc;
    endfunction

endpackage

//--- design/aesSubWord.sv
/*
 * Registered S-box substitution of the four bytes of a word
 * Shared by key expansion and the round datapath
 */
`timescale 1ns/100ps
`include "aes_consts.svh"

module aesSubWord import aesPkg::*; (
    input  logic   clk,
    input  aesWord wordIn,
    output aesWord wordOut
);

    localparam int BYTES = `AES_WORD_W / `AES_BYTE_W;

    aesWord subbed;

    // One lookup per byte lane
    always_comb begin
        for (int i = 0; i < BYTES; i++) begin
            subbed[i*`AES_BYTE_W +: `AES_BYTE_W] =
                sboxByte(wordIn[i*`AES_BYTE_W +: `AES_BYTE_W]);
        end
    end

    always_ff @(posedge clk) begin
        wordOut <= subbed;
    end

endmodule

//--- design/aesKeyStage.sv
/*
 * One AES-128 key expansion step
 * Round key is ready with the round stage's second cycle
 */
`timescale 1ns/100ps

module aesKeyStage import aesPkg::*; #(
    parameter aesByte roundConstant = 8'h01
) (
    input  logic    clk,
    input  aesBlock keyIn,
    output aesBlock roundKey,
    output aesBlock keyOut
);

    aesWord k0, k1, k2, k3;
    aesWord v0, v1, v2, v3;
    aesWord v0Q, v1Q, v2Q, v3Q;
    aesWord subWord;

    assign {k0, k1, k2, k3} = keyIn;

    //////////////////////////////////////////////////
    // Running XOR words
    //////////////////////////////////////////////////

    // Round constant only touches the top byte of word 0
    assign v0 = {k0[31:24] ^ roundConstant, k0[23:0]};
    assign v1 = v0 ^ k1;
    assign v2 = v1 ^ k2;
    assign v3 = v2 ^ k3;

    always_ff @(posedge clk) begin
        v0Q <= v0;
        v1Q <= v1;
        v2Q <= v2;
        v3Q <= v3;
    end

    // RotWord then SubWord, same cycle as the XOR words
    aesSubWord uSubWord (
        .clk     (clk),
        .wordIn  ({k3[23:0], k3[31:24]}),
        .wordOut (subWord)
    );

    assign roundKey = {v0Q ^ subWord, v1Q ^ subWord, v2Q ^ subWord, v3Q ^ subWord};

    // Next stage sees the key two cycles after this one
    always_ff @(posedge clk) begin
        keyOut <= roundKey;
    end

endmodule

//--- design/aesRoundStage.sv
/*
 * One AES round over two cycles
 * Cycle one registers SubBytes, cycle two registers the
 * ShiftRows / MixColumns / AddRoundKey result
 */
`timescale 1ns/100ps
`include "aes_consts.svh"

module aesRoundStage import aesPkg::*; #(
    parameter bit finalRound = 1'b0
) (
    input  logic    clk,
    input  aesBlock stateIn,
    input  aesBlock roundKey,
    output aesBlock stateOut
);

    localparam int COLS = `AES_BLOCK_W / `AES_WORD_W;

    aesWord subWord [COLS];
    aesWord shifted [COLS];
    aesBlock mixed;

    // Column mix for one word, rows 0..3 from the top byte down
    function automatic aesWord mixColumn(input aesWord w);
        aesByte a0, a1, a2, a3;
        aesByte m0, m1, m2, m3;
        {a0, a1, a2, a3} = w;
        m0 = xtimeByte(a0) ^ xtimeByte(a1) ^ a1 ^ a2 ^ a3;
        m1 = a0 ^ xtimeByte(a1) ^ xtimeByte(a2) ^ a2 ^ a3;
        m2 = a0 ^ a1 ^ xtimeByte(a2) ^ xtimeByte(a3) ^ a3;
        m3 = xtimeByte(a0) ^ a0 ^ a1 ^ a2 ^ xtimeByte(a3);
        return {m0, m1, m2, m3};
    endfunction

    //////////////////////////////////////////////////
    // SubBytes, one word per column
    //////////////////////////////////////////////////

    for (genvar c = 0; c < COLS; c++) begin : gSub
        aesSubWord uSubWord (
            .clk     (clk),
            .wordIn  (stateIn[`AES_BLOCK_W-1-c*`AES_WORD_W -: `AES_WORD_W]),
            .wordOut (subWord[c])
        );
    end

    //////////////////////////////////////////////////
    // ShiftRows and MixColumns
    //////////////////////////////////////////////////

    // Row r of column c comes from column c+r
    always_comb begin
        for (int c = 0; c < COLS; c++) begin
            for (int r = 0; r < 4; r++) begin
                shifted[c][`AES_WORD_W-1-r*`AES_BYTE_W -: `AES_BYTE_W] =
                    subWord[(c + r) % COLS][`AES_WORD_W-1-r*`AES_BYTE_W -: `AES_BYTE_W];
            end
        end
    end

    always_comb begin
        for (int c = 0; c < COLS; c++) begin
            if (finalRound) begin
                mixed[`AES_BLOCK_W-1-c*`AES_WORD_W -: `AES_WORD_W] = shifted[c];
            end else begin
                mixed[`AES_BLOCK_W-1-c*`AES_WORD_W -: `AES_WORD_W] = mixColumn(shifted[c]);
            end
        end
    end

    // AddRoundKey into the stage output register
    always_ff @(posedge clk) begin
        stateOut <= mixed ^ roundKey;
    end

endmodule

//--- design/aesLaunchCtrl.sv
/*
 * AES launch controller
 * Captures each strobed block, whitens it with its key and
 * carries the strobe alongside the pipeline to the output
 */
`timescale 1ns/100ps
`include "aes_consts.svh"

module aesLaunchCtrl import aesPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    inStrobe,
    input  aesBlock plainText,
    input  aesBlock cipherKey,
    output aesBlock roundState0,
    output aesBlock stageKey0,
    output logic    outStrobe
);

    logic [`AES_LATENCY-1:0] validLine;

    // Datapath runs every cycle, strobe or not
    always_ff @(posedge clk) begin
        roundState0 <= plainText ^ cipherKey;
        stageKey0 <= cipherKey;
    end

    //////////////////////////////////////////////////
    // Slot tracking
    //////////////////////////////////////////////////

    // One bit per pipeline slot, whitening slot first
    always_ff @(posedge clk) begin
        if (rst) begin
            validLine <= '0;
        end else begin
            validLine <= {validLine[`AES_LATENCY-2:0], inStrobe};
        end
    end

    assign outStrobe = validLine[`AES_LATENCY-1];

endmodule

//--- design/aesCore.sv
/*
 * Fully pipelined AES-128 encryption core
 * One block and key per cycle, ciphertext after a fixed latency
 */
`timescale 1ns/100ps
`include "aes_consts.svh"

module aesCore import aesPkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    inStrobe,
    input  aesBlock plainText,
    input  aesBlock cipherKey,
    output logic    outStrobe,
    output aesBlock cipherText
);

    // Index n holds what stage n produces, 0 is the launch controller
    aesBlock stateChain [`AES_ROUNDS+1];
    aesBlock keyChain [`AES_ROUNDS];
    aesBlock roundKeys [`AES_ROUNDS];

    aesLaunchCtrl uLaunch (
        .clk         (clk),
        .rst         (rst),
        .inStrobe    (inStrobe),
        .plainText   (plainText),
        .cipherKey   (cipherKey),
        .roundState0 (stateChain[0]),
        .stageKey0   (keyChain[0]),
        .outStrobe   (outStrobe)
    );

    //////////////////////////////////////////////////
    // Round pipeline
    //////////////////////////////////////////////////

    for (genvar n = 0; n < `AES_ROUNDS; n++) begin : gRound
        if (n < `AES_ROUNDS - 1) begin : gKey
            aesKeyStage #(
                .roundConstant (roundConst(n + 1))
            ) uKeyStage (
                .clk      (clk),
                .keyIn    (keyChain[n]),
                .roundKey (roundKeys[n]),
                .keyOut   (keyChain[n+1])
            );
        end else begin : gLastKey
            // No key stage follows the last round
            aesKeyStage #(
                .roundConstant (roundConst(n + 1))
            ) uKeyStage (
                .clk      (clk),
                .keyIn    (keyChain[n]),
                .roundKey (roundKeys[n]),
                .keyOut   ()
            );
        end

        aesRoundStage #(
            .finalRound (n == `AES_ROUNDS - 1)
        ) uRoundStage (
            .clk      (clk),
            .stateIn  (stateChain[n]),
            .roundKey (roundKeys[n]),
            .stateOut (stateChain[n+1])
        );
    end

    assign cipherText = stateChain[`AES_ROUNDS];

endmodule

//--- bench/aesCoreTb.sv
/*
 * Testbench for the pipelined AES-128 core
 * Issues file vectors alone, back to back and with random gaps,
 * and checks ciphertext, latency and strobe count
 */
`timescale 1ns/100ps

module aesCoreTb import aesPkg::*; ();

    localparam int WAIT_LIMIT = 200;

    // Whitening cycle plus ten rounds of two cycles each
    localparam int LATENCY = 21;

    logic    clk = 1'b0;
    logic    rst;
    logic    inStrobe;
    aesBlock plainText;
    aesBlock cipherKey;
    logic    outStrobe;
    aesBlock cipherText;

    // Vectors from the input file
    aesBlock keyVec [$];
    aesBlock ptVec [$];
    aesBlock ctVec [$];

    // Scoreboard, one entry per block in flight
    aesBlock expQ [$];
    int      issueQ [$];

    int     cycleCount = 0;
    int     inCount = 0;
    int     outCount = 0;
    bit     monitorOn = 1'b0;
    integer seed = 32'h5b6b7890;

    aesCore i_dut (
        .clk        (clk),
        .rst        (rst),
        .inStrobe   (inStrobe),
        .plainText  (plainText),
        .cipherKey  (cipherKey),
        .outStrobe  (outStrobe),
        .cipherText (cipherText)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
    end

    //////////////////////////////////////////////////
    // Reporting
    //////////////////////////////////////////////////

    task automatic stopRun(input string reason);
        $display("%s", reason);
        $display("SOME TESTS FAILED");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkValue(input string name, input aesBlock actual, input aesBlock expected);
        if (actual !== expected) begin
            $display("error: %s is %h, expected %h", name, actual, expected);
            stopRun("value mismatch");
        end
    endtask

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    task automatic loadVectors();
        int      fd;
        int      got;
        string   line;
        aesBlock k;
        aesBlock p;
        aesBlock c;
        fd = $fopen("bench/aes_input_vectors.txt", "r");
        if (fd == 0) begin
            stopRun("could not open bench/aes_input_vectors.txt");
        end
        while (!$feof(fd)) begin
            got = $fgets(line, fd);
            // Comment and blank lines give no hex fields
            if (got > 0 && $sscanf(line, "%h %h %h", k, p, c) == 3) begin
                keyVec.push_back(k);
                ptVec.push_back(p);
                ctVec.push_back(c);
            end
        end
        $fclose(fd);
        if (keyVec.size() == 0) begin
            stopRun("no test vectors found in the input file");
        end
    endtask

    // Called on a falling edge, returns on the next one
    task automatic sendBlock(input int idx);
        cipherKey = keyVec[idx];
        plainText = ptVec[idx];
        inStrobe = 1'b1;
        expQ.push_back(ctVec[idx]);
        // Edge that samples this strobe
        issueQ.push_back(cycleCount + 1);
        inCount++;
        @(negedge clk);
        inStrobe = 1'b0;
    endtask

    // Junk on the data inputs while no strobe is given
    task automatic idleCycles(input int n);
        repeat (n) begin
            plainText = {$random(seed), $random(seed), $random(seed), $random(seed)};
            cipherKey = {$random(seed), $random(seed), $random(seed), $random(seed)};
            @(negedge clk);
        end
    endtask

    task automatic waitDrain(input string what);
        int waited;
        waited = 0;
        while (expQ.size() != 0) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                stopRun({"outStrobe never came for the ", what});
            end
        end
    endtask

    //////////////////////////////////////////////////
    // Output monitor
    //////////////////////////////////////////////////

    always @(negedge clk) begin : outMonitor
        aesBlock expCt;
        int      issued;
        // Every pulse counts, reset included
        if (outStrobe === 1'b1) begin
            outCount++;
        end
        if (monitorOn) begin
            if (outStrobe === 1'b1) begin
                if (expQ.size() == 0) begin
                    stopRun("outStrobe pulsed with no block in flight");
                end
                expCt = expQ.pop_front();
                issued = issueQ.pop_front();
                checkValue("cipherText", cipherText, expCt);
                checkValue("latency", aesBlock'(cycleCount + 1 - issued),
                    aesBlock'(LATENCY));
            end else begin
                checkValue("outStrobe", aesBlock'(outStrobe), aesBlock'(0));
            end
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin : mainSeq
        int gap;
        rst = 1'b1;
        inStrobe = 1'b0;
        plainText = '0;
        cipherKey = '0;
        loadVectors();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        monitorOn = 1'b1;

        // Quiet pipeline after reset
        idleCycles(30);

        // Each vector alone
        for (int i = 0; i < keyVec.size(); i++) begin
            sendBlock(i);
            waitDrain("single block");
            idleCycles(3);
        end

        // Back to back, more blocks than pipeline slots
        for (int i = 0; i < 2 * keyVec.size(); i++) begin
            sendBlock(i % keyVec.size());
        end
        waitDrain("back-to-back burst");
        idleCycles(3);

        // Random gaps of 0 to 5 cycles
        for (int i = 0; i < 3 * keyVec.size(); i++) begin
            sendBlock(i % keyVec.size());
            gap = $unsigned($random(seed)) % 6;
            idleCycles(gap);
        end
        waitDrain("random-gap sequence");
        idleCycles(30);

        if (outCount == inCount) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            checkValue("outStrobe count", aesBlock'(outCount), aesBlock'(inCount));
        end
    end

endmodule

//--- bench/aes_input_vectors.txt
# AES-128 known-answer vectors, FIPS-197 appendices, SP 800-38A ECB and AESAVS
# columns: key plaintext expected_ciphertext, all 128-bit hex
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
00000000000000000000000000000000 f34481ec3cc627bacd5dc3fb08f273e6 0336763e966d92595a567cc9ce537f5e
00000000000000000000000000000000 9798c4640bad75c7c3227db910174e72 a9a1631bf4996954ebc093957b234589
00000000000000000000000000000000 96ab5c2ff612d9dfaae8c31f30c42168 ff4f8391a6a40ca5b25d23bedd44a597
00000000000000000000000000000000 6a118a874519e64e9963798a503f1d35 dc43be40be0e53712f7e2bf5ca707209
00000000000000000000000000000000 cb9fceec81286ca3e989bd979b0cb284 92beedab1895a94faa69b632e5cc47ce
00000000000000000000000000000000 58c8e00b2631686d54eab84b91f0aca1 08a4e2efec8a8e3312ca7460b9040bbf
10a58869d74be5a374cf867cfb473859 00000000000000000000000000000000 6d251e6944b051e04eaa6fb4dbf78465
caea65cdbb75e9169ecd22ebe6e54675 00000000000000000000000000000000 6e29201190152df4ee058139def610bb
00000000000000000000000000000000 80000000000000000000000000000000 3ad78e726c1ec02b7ebfe92b23d9ec34

//--- vlog.f
+incdir+design
design/aesPkg.sv
design/aesSubWord.sv
design/aesKeyStage.sv
design/aesRoundStage.sv
design/aesLaunchCtrl.sv
design/aesCore.sv
bench/aesCoreTb.sv

//--- run.sh
#!/bin/sh
# Build and run the AES core testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f vlog.f --top-module aesCoreTb -o aesCoreSim \
    && ./obj_dir/aesCoreSim > sim.log 2>&1 \
    || echo "build or simulation returned an error"
[ -f sim.log ] && cat sim.log
grep -q "ALL TESTS PASSED" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }
